//--- common/physics_pkg.sv
package physics_pkg;

	typedef logic [1:0] player_id_t;           // Up to four players
	typedef logic signed [15:0] coord_t;       // Whole pixels
	typedef logic signed [31:0] fixed_t;       // 16.16 fixed point
	typedef logic [7:0] joystick_t;            // Raw axis, rests at 128
	typedef logic [15:0] damage_t;             // Damage percent

	// Wall contact flags reported by the collision logic
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
		logic platform;
	} contact_t;

	typedef enum logic [0:0] {
		CMD_SPAWN = 1'b0,
		CMD_STEP  = 1'b1
	} cmd_kind_e;

	typedef struct packed {
		cmd_kind_e kind;
		player_id_t player;
		joystick_t joy_x;
		joystick_t joy_y;
		logic jump_button;
		contact_t contact;
		logic attack;
		logic freeze;
		coord_t knockback_x;
		coord_t knockback_y;
		coord_t movement_x;        // Attack movement in pixels
		coord_t movement_y;
		damage_t damage;
		coord_t spawn_x;
		coord_t spawn_y;
	} physics_cmd_t;

	typedef struct packed {
		player_id_t player;
		coord_t pos_x;
		coord_t pos_y;
	} position_t;

	// Joystick gain, scaled before the divide by mass
	localparam fixed_t MOVE_SCALE = 32'sd1024;
	localparam fixed_t JUMP_IMPULSE = 32'sh0004_0000;

	localparam joystick_t JOY_CENTER = 8'd128;
	localparam joystick_t JOY_UP_LIMIT = 8'd240;    // At or above counts as a jump press
	localparam joystick_t JOY_DOWN_LIMIT = 8'd16;   // Below drops through platforms

endpackage

//--- physics_unit/physics_unit.sv
`timescale 1ns/1ps

module physics_unit import physics_pkg::*; #(
	parameter player_id_t PLAYER = '0
) (
	input logic clock,
	input logic reset,
	input fixed_t mass,
	input fixed_t gravity,
	input logic step,
	input physics_cmd_t cmd,
	output logic ready,
	output logic result_valid,
	output position_t result,
	input logic take
);

	fixed_t pos_x, pos_y;
	fixed_t vel_x, vel_y;
	logic press_prev;          // Jump press seen on the last step

	fixed_t nxt_pos_x, nxt_pos_y;
	fixed_t nxt_vel_x, nxt_vel_y;
	logic nxt_press;

	logic press;
	logic grounded;
	logic jump_edge;
	fixed_t joy_off;
	fixed_t walk_vel;
	fixed_t jump_vel;

	// Knockback grows with damage, result lands in the fraction bits
	function automatic fixed_t scale_knockback(input coord_t kb, input damage_t dmg);
		logic signed [17:0] mult;
		logic signed [35:0] prod;
		logic signed [35:0] quot;
		mult = $signed({2'b00, dmg}) + 18'sd100;
		prod = kb * mult;
		quot = prod / 36'sd100;    // Truncates toward zero
		return fixed_t'(quot <<< 4);
	endfunction

	// Controller decode
	assign press = cmd.jump_button | (cmd.joy_y >= JOY_UP_LIMIT);
	assign grounded = cmd.contact.down | (cmd.contact.platform & (cmd.joy_y >= JOY_DOWN_LIMIT));
	assign jump_edge = press & ~press_prev;

	assign joy_off = fixed_t'(cmd.joy_x) - fixed_t'(JOY_CENTER);
	assign walk_vel = (joy_off * MOVE_SCALE) / mass;
	assign jump_vel = JUMP_IMPULSE / mass;

	always_comb begin
		nxt_pos_x = pos_x;
		nxt_pos_y = pos_y;
		nxt_vel_x = vel_x;
		nxt_vel_y = vel_y;
		nxt_press = press_prev;

		if (cmd.kind == CMD_SPAWN) begin
			nxt_pos_x = {cmd.spawn_x, 16'h0000};
			nxt_pos_y = {cmd.spawn_y, 16'h0000};
			nxt_vel_x = '0;
			nxt_vel_y = '0;
			nxt_press = 1'b0;
		end else if (cmd.attack) begin
			nxt_vel_x = scale_knockback(cmd.knockback_x, cmd.damage);
			nxt_vel_y = scale_knockback(cmd.knockback_y, cmd.damage);
			nxt_pos_x = pos_x + (fixed_t'(cmd.movement_x) <<< 16);
			nxt_pos_y = pos_y + (fixed_t'(cmd.movement_y) <<< 16);
			nxt_press = press;
		end else if (!cmd.freeze) begin
			nxt_vel_x = walk_vel;
			if (grounded)
				nxt_vel_y = jump_edge ? jump_vel : '0;
			else
				nxt_vel_y = vel_y - gravity;

			// Walls stop motion only in the direction they face
			if (!(nxt_vel_x > 0 && cmd.contact.right) && !(nxt_vel_x < 0 && cmd.contact.left))
				nxt_pos_x = pos_x + nxt_vel_x;
			if (!(nxt_vel_y > 0 && cmd.contact.up))
				nxt_pos_y = pos_y + nxt_vel_y;
			nxt_press = press;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pos_x <= '0;
			pos_y <= '0;
			vel_x <= '0;
			vel_y <= '0;
			press_prev <= 1'b0;
		end else if (step) begin
			pos_x <= nxt_pos_x;
			pos_y <= nxt_pos_y;
			vel_x <= nxt_vel_x;
			vel_y <= nxt_vel_y;
			press_prev <= nxt_press;
		end
	end

	// Result slot, one entry
	always_ff @(posedge clock) begin
		if (reset)
			result_valid <= 1'b0;
		else if (step)
			result_valid <= 1'b1;
		else if (take)
			result_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (step) begin
			result.player <= PLAYER;
			result.pos_x <= nxt_pos_x[31:16];   // Integer pixels
			result.pos_y <= nxt_pos_y[31:16];
		end
	end

	assign ready = ~result_valid;

endmodule

//--- source/command_dispatcher.sv
`timescale 1ns/1ps

module command_dispatcher import physics_pkg::*; #(
	parameter int NUM_PLAYERS = 4,
	parameter int CMD_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	input physics_cmd_t cmd,
	output logic cmd_credit,
	output logic [NUM_PLAYERS-1:0] unit_step,
	output physics_cmd_t unit_cmd,
	input logic [NUM_PLAYERS-1:0] unit_ready
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	physics_cmd_t fifo_mem [CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;
	logic push;

	// Sender holds a credit whenever it asserts valid, so no full check
	assign push = cmd_valid;
	assign unit_cmd = fifo_mem[rd_ptr];
	assign pop = (count != '0) && unit_ready[unit_cmd.player];

	always_comb begin
		unit_step = '0;
		if (pop)
			unit_step[unit_cmd.player] = 1'b1;
	end

	assign cmd_credit = pop;    // Slot freed

	always_ff @(posedge clock) begin
		if (push)
			fifo_mem[wr_ptr] <= cmd;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/position_collector.sv
`timescale 1ns/1ps

module position_collector import physics_pkg::*; #(
	parameter int NUM_PLAYERS = 4,
	parameter int OUT_CREDITS = 2
) (
	input logic clock,
	input logic reset,
	input logic [NUM_PLAYERS-1:0] result_valid,
	input position_t result [NUM_PLAYERS],
	output logic [NUM_PLAYERS-1:0] result_take,
	output logic out_valid,
	output position_t out_pos,
	input logic out_credit
);

	localparam int SEL_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	logic [SEL_W-1:0] rr_ptr;
	logic [SEL_W-1:0] sel;
	logic found;
	logic send;
	logic [CRED_W-1:0] credits;

	// First valid unit at or after the pointer
	always_comb begin
		int idx;
		sel = '0;
		found = 1'b0;
		for (int k = NUM_PLAYERS - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % NUM_PLAYERS;
			if (result_valid[idx]) begin
				sel = SEL_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign send = found && (credits != '0);

	always_comb begin
		result_take = '0;
		if (send)
			result_take[sel] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rr_ptr <= '0;
			credits <= CRED_W'(OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= send;
			if (send)
				rr_ptr <= (sel == SEL_W'(NUM_PLAYERS - 1)) ? '0 : sel + 1'b1;
			credits <= credits - CRED_W'(send) + CRED_W'(out_credit);
		end
	end

	always_ff @(posedge clock) begin
		if (send)
			out_pos <= result[sel];
	end

endmodule

//--- source/physics_top.sv
`timescale 1ns/1ps

module physics_top import physics_pkg::*; #(
	parameter int NUM_PLAYERS = 4,
	parameter int CMD_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input logic clock,
	input logic reset,
	input fixed_t mass,
	input fixed_t gravity,
	input logic cmd_valid,
	input physics_cmd_t cmd,
	output logic cmd_credit,
	output logic out_valid,
	output position_t out_pos,
	input logic out_credit
);

	logic [NUM_PLAYERS-1:0] unit_step;
	logic [NUM_PLAYERS-1:0] unit_ready;
	physics_cmd_t unit_cmd;     // Shared by all units
	logic [NUM_PLAYERS-1:0] result_valid;
	logic [NUM_PLAYERS-1:0] result_take;
	position_t result [NUM_PLAYERS];

	command_dispatcher #(
		.NUM_PLAYERS(NUM_PLAYERS),
		.CMD_DEPTH(CMD_DEPTH)
	) dispatcher (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.unit_step(unit_step),
		.unit_cmd(unit_cmd),
		.unit_ready(unit_ready)
	);

	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_unit
		physics_unit #(
			.PLAYER(player_id_t'(i))
		) unit (
			.clock(clock),
			.reset(reset),
			.mass(mass),
			.gravity(gravity),
			.step(unit_step[i]),
			.cmd(unit_cmd),
			.ready(unit_ready[i]),
			.result_valid(result_valid[i]),
			.result(result[i]),
			.take(result_take[i])
		);
	end

	position_collector #(
		.NUM_PLAYERS(NUM_PLAYERS),
		.OUT_CREDITS(OUT_CREDITS)
	) collector (
		.clock(clock),
		.reset(reset),
		.result_valid(result_valid),
		.result(result),
		.result_take(result_take),
		.out_valid(out_valid),
		.out_pos(out_pos),
		.out_credit(out_credit)
	);

endmodule

//--- tb/tb_physics.sv
`timescale 1ns/1ps

module tb_physics import physics_pkg::*; ();

	localparam int NUM_PLAYERS = 4;
	localparam int CMD_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_CMD = 40;
	localparam int MEM_WORDS = 512;
	localparam int MAX_CMDS = 64;
	localparam int CMD_WORDS = 16;     // Tag plus 15 command fields
	localparam int EXP_WORDS = 4;      // Tag, player, x, y
	localparam fixed_t MASS = 32'sh0000_0001;
	localparam fixed_t GRAVITY = 32'sh0000_4000;   // Quarter pixel per step

	logic clock;
	logic reset;
	fixed_t mass;
	fixed_t gravity;
	logic cmd_valid;
	physics_cmd_t cmd;
	logic cmd_credit;
	logic out_valid;
	position_t out_pos;
	logic out_credit;

	logic [15:0] data_mem [MEM_WORDS];
	physics_cmd_t cmd_list [MAX_CMDS];
	position_t exp_q [$];
	int credit_due [$];
	int num_cmds;
	int num_expected;
	int cmd_idx;
	int cmd_credits;
	int results_seen;
	int cycle_count;
	int timeout_limit;
	int out_tick;
	int last_due;
	integer seed;
	logic running;

	physics_top #(
		.NUM_PLAYERS(NUM_PLAYERS),
		.CMD_DEPTH(CMD_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) UUT (
		.clock(clock),
		.reset(reset),
		.mass(mass),
		.gravity(gravity),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.out_valid(out_valid),
		.out_pos(out_pos),
		.out_credit(out_credit)
	);

	always #10 clock = ~clock;

	task automatic abort_run(input string reason);
		$display("*** FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input coord_t got, input coord_t want);
		if (got !== want) begin
			$display("** Error: %s is %h, expected %h", name, got, want);
			abort_run("output position does not match the expected value");
		end
	endtask

	function automatic physics_cmd_t build_cmd(input int base);
		physics_cmd_t c;
		c = '0;
		c.player = player_id_t'(data_mem[base]);
		c.kind = data_mem[base + 1][0] ? CMD_STEP : CMD_SPAWN;
		c.joy_x = joystick_t'(data_mem[base + 2]);
		c.joy_y = joystick_t'(data_mem[base + 3]);
		c.jump_button = data_mem[base + 4][0];
		c.contact = contact_t'(data_mem[base + 5][4:0]);   // left right up down platform
		c.attack = data_mem[base + 6][0];
		c.freeze = data_mem[base + 7][0];
		c.knockback_x = coord_t'(data_mem[base + 8]);
		c.knockback_y = coord_t'(data_mem[base + 9]);
		c.movement_x = coord_t'(data_mem[base + 10]);
		c.movement_y = coord_t'(data_mem[base + 11]);
		c.damage = damage_t'(data_mem[base + 12]);
		c.spawn_x = coord_t'(data_mem[base + 13]);
		c.spawn_y = coord_t'(data_mem[base + 14]);
		return c;
	endfunction

	// Walk the tagged records until the zero end marker
	task automatic load_testdata();
		int pos;
		position_t p;
		for (int i = 0; i < MEM_WORDS; i++)
			data_mem[i] = '0;
		$readmemh("tb/physics_testdata.txt", data_mem);
		pos = 0;
		while (data_mem[pos] != 16'h0000 && pos < MEM_WORDS - CMD_WORDS) begin
			if (data_mem[pos] == 16'h0001) begin
				if (num_cmds == MAX_CMDS)
					abort_run("data file holds more commands than the command table");
				cmd_list[num_cmds] = build_cmd(pos + 1);
				num_cmds++;
				pos += CMD_WORDS;
			end else if (data_mem[pos] == 16'h0002) begin
				p.player = player_id_t'(data_mem[pos + 1]);
				p.pos_x = coord_t'(data_mem[pos + 2]);
				p.pos_y = coord_t'(data_mem[pos + 3]);
				exp_q.push_back(p);
				num_expected++;
				pos += EXP_WORDS;
			end else begin
				abort_run($sformatf("unknown record tag %h in the data file", data_mem[pos]));
			end
		end
	endtask

	// Command sender, one credit per command
	always @(posedge clock) begin
		int avail;
		if (running) begin
			avail = cmd_credits + (cmd_credit ? 1 : 0);
			if (cmd_idx < num_cmds && avail > 0) begin
				cmd_valid <= 1'b1;
				cmd <= cmd_list[cmd_idx];
				cmd_idx = cmd_idx + 1;
				avail = avail - 1;
			end else begin
				cmd_valid <= 1'b0;
			end
			cmd_credits = avail;
		end
	end

	// Output checker and delayed credit return
	always @(posedge clock) begin
		int hit;
		int delay;
		int due;
		if (running) begin
			out_tick = out_tick + 1;
			if (out_valid) begin
				hit = -1;
				for (int i = exp_q.size() - 1; i >= 0; i--)
					if (exp_q[i].player == out_pos.player)
						hit = i;    // Oldest entry for this player
				if (hit < 0) begin
					abort_run($sformatf("result for player %0d arrived with none expected",
						out_pos.player));
				end else begin
					check_value("out_pos.pos_x", out_pos.pos_x, exp_q[hit].pos_x);
					check_value("out_pos.pos_y", out_pos.pos_y, exp_q[hit].pos_y);
					exp_q.delete(hit);
					results_seen = results_seen + 1;
				end
				delay = $unsigned($random(seed)) % 4;
				due = out_tick + delay;
				if (due <= last_due)
					due = last_due + 1;   // One pulse per cycle
				last_due = due;
				credit_due.push_back(due);
			end
			if (credit_due.size() != 0 && credit_due[0] <= out_tick) begin
				out_credit <= 1'b1;
				void'(credit_due.pop_front());
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	// Results still queued when the limit is reached end the run here
	always @(posedge clock) begin
		if (running) begin
			cycle_count = cycle_count + 1;
			if (cycle_count > timeout_limit) begin
				abort_run($sformatf("timeout after %0d cycles, %0d of %0d results seen",
					cycle_count, results_seen, num_expected));
			end
		end
	end

	initial begin
		seed = 64;
		clock = 1'b0;
		reset = 1'b1;
		mass = MASS;
		gravity = GRAVITY;
		cmd_valid = 1'b0;
		cmd = '0;
		out_credit = 1'b0;
		running = 1'b0;
		num_cmds = 0;
		num_expected = 0;
		cmd_idx = 0;
		cmd_credits = CMD_DEPTH;
		results_seen = 0;
		cycle_count = 0;
		out_tick = 0;
		last_due = -1;
		load_testdata();
		timeout_limit = num_cmds * CYCLES_PER_CMD;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		running <= 1'b1;

		wait (results_seen == num_expected);
		repeat (8) @(posedge clock);    // Catch any stray result
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- tb/physics_testdata.txt
// 1 player kind joy_x joy_y jump contact attack freeze kb_x kb_y mv_x mv_y damage spawn_x spawn_y
// 2 player pos_x pos_y (expected result), contact bits are left right up down platform, 0 ends
1 0 0 80 80 0 00 0 0 0000 0000 0000 0000 0000 0064 0032
2 0 0064 0032
1 1 0 80 80 0 00 0 0 0000 0000 0000 0000 0000 00C8 000A
2 1 00C8 000A
1 2 0 80 80 0 00 0 0 0000 0000 0000 0000 0000 012C 0000
2 2 012C 0000
1 3 0 80 80 0 00 0 0 0000 0000 0000 0000 0000 FFF6 0064
2 3 FFF6 0064
1 0 1 80 80 0 02 0 0 0000 0000 0000 0000 0000 0000 0000
2 0 0064 0032
1 1 1 80 80 1 02 0 0 0000 0000 0000 0000 0000 0000 0000
2 1 00C8 000E
1 2 1 80 80 0 00 1 0 0100 1000 0005 FFFE 0064 0000 0000
2 2 0131 FFFE
1 3 1 C0 80 0 02 0 0 0000 0000 0000 0000 0000 0000 0000
2 3 FFF7 0064
1 0 1 C0 80 0 02 0 0 0000 0000 0000 0000 0000 0000 0000
2 0 0065 0032
1 1 1 80 80 1 00 0 0 0000 0000 0000 0000 0000 0000 0000
2 1 00C8 0011
1 2 1 80 80 0 00 0 0 0000 0000 0000 0000 0000 0000 0000
2 2 0131 FFFF
1 3 1 80 08 0 01 0 0 0000 0000 0000 0000 0000 0000 0000
2 3 FFF7 0063
1 0 1 C0 80 0 0A 0 0 0000 0000 0000 0000 0000 0000 0000
2 0 0065 0032
1 1 1 80 80 1 00 0 0 0000 0000 0000 0000 0000 0000 0000
2 1 00C8 0015
1 2 1 FF 80 1 00 0 1 0000 0000 0000 0000 0000 0000 0000
2 2 0131 FFFF
1 0 1 40 80 0 0A 0 0 0000 0000 0000 0000 0000 0000 0000
2 0 0064 0032
1 1 1 80 80 1 02 0 0 0000 0000 0000 0000 0000 0000 0000
2 1 00C8 0015
1 2 1 80 80 0 00 0 0 0000 0000 0000 0000 0000 0000 0000
2 2 0131 0001
0

//--- flist.f
common/physics_pkg.sv
physics_unit/physics_unit.sv
source/command_dispatcher.sv
source/position_collector.sv
source/physics_top.sv
tb/tb_physics.sv

//--- Makefile
SIM = verilator
FLAGS = --binary --timing -j 0
TOP = tb_physics
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
